// ==== testbench/uop_stimulus.txt ====
// Header: count[59:52] _ 0000 _ flags (flush,hold,fiq,irq) _ instruction
// Micro-op line: stall _ expected 35-bit micro-op
// MOV r1, r2 with irq and fiq
01_0000_3_E1A01002
0_0E1A01002
// LDMIA r0, {r1-r3} with random hold and irq
05_0000_5_E890000E
1_2E1A00000
1_1E4901004
1_1E4902004
1_1E4903004
0_000000000
// STMDB r13!, {r4, r5, lr} with random hold and fiq
05_0000_6_E92D4030
1_2E24D000C
1_1E4804004
1_1E4805004
1_1E480E004
0_0E24DD00C
// LDMIA r1!, {r0, pc}^ with irq
05_0000_5_E8F18001
1_2E1A00001
1_1E4900004
1_3E4901004
1_4E1A01000
0_4E1B0F001
// SWP r2, r3, [r4] with hold, irq and fiq
04_0000_7_E1042093
1_2E5940000
1_0E5843000
1_4E1A02000
0_0E5843000
// SWPB r5, r6, [r7] with random hold
04_0000_4_E1475096
1_2E5D70000
1_0E5C76000
1_4E1A05000
0_0E5C76000
// LDMIA r0, {r1-r3} flushed after two micro-ops
02_0000_9_E890000E
1_2E1A00000
1_1E4901004
// MOV r3, r4 right after the flush
01_0000_2_E1A03004
0_0E1A03004
// End of records
0

// ==== build.f ====
design/uop_seq_pkg.sv
design/uop_seq_fsm.sv
design/reglist_tracker.sv
design/uop_encoder.sv
design/uop_sequencer.sv
testbench/uop_sequencer_sva.sv
testbench/tb_uop_sequencer.sv

// ==== Makefile ====
# Verilator build and run of the micro-op sequencer testbench.

TOP = tb_uop_sequencer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_uop_sequencer.sv ====
// Testbench of the micro-op sequencer.
// Clock, reset, file-driven stimulus with random hold,
// compare tasks, watchdog and the closing report.

`timescale 1ns/1ps
`default_nettype none

module tb_uop_sequencer;

logic                     i_clk;
logic                     i_reset;
logic                     i_flush;
logic                     i_hold;
logic                     i_valid;
logic                     i_irq;
logic                     i_fiq;
uop_seq_pkg::instr_t      i_instruction;
uop_seq_pkg::uop_t        o_uop;
logic                     o_uop_valid;
logic                     o_stall;
logic                     o_irq;
logic                     o_fiq;

// Header and micro-op lines, see the stimulus file.
logic [63:0] stim_mem [0:63];

int          errors;
int          checks;
int          tests;
int unsigned limit_cycles;

uop_sequencer uop_sequencer_i
(
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_flush       (i_flush),
        .i_hold        (i_hold),
        .i_valid       (i_valid),
        .i_irq         (i_irq),
        .i_fiq         (i_fiq),
        .i_instruction (i_instruction),
        .o_uop         (o_uop),
        .o_uop_valid   (o_uop_valid),
        .o_stall       (o_stall),
        .o_irq         (o_irq),
        .o_fiq         (o_fiq)
);

initial
begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
end

////////////////////////////////////////////////////////////
// Compare tasks.
////////////////////////////////////////////////////////////

task automatic check_uop(input string name, input uop_seq_pkg::uop_t got,
                         input uop_seq_pkg::uop_t exp);
begin
        checks++;
        if (got !== exp)
        begin
                errors++;
                $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
begin
        checks++;
        if (got !== exp)
        begin
                errors++;
                $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
end
endtask

// Sample in mid-cycle, then step past the next edge.
task automatic sample_step(input uop_seq_pkg::uop_t exp_uop, input logic exp_stall,
                           input logic exp_irq, input logic exp_fiq);
begin
        @(negedge i_clk);
        check_uop("o_uop", o_uop, exp_uop);
        check_bit("o_stall", o_stall, exp_stall);
        check_bit("o_uop_valid", o_uop_valid, 1'b1);
        check_bit("o_irq", o_irq, exp_irq);
        check_bit("o_fiq", o_fiq, exp_fiq);
        @(posedge i_clk);
        #1;
end
endtask

////////////////////////////////////////////////////////////
// One instruction and its micro-ops.
////////////////////////////////////////////////////////////

task automatic run_record(input logic [63:0] hdr, input int first);
        int                count;
        int                holds;
        int                errs_before;
        logic              hold_en;
        logic              flush_en;
        logic              first_irq;
        logic              first_fiq;
        uop_seq_pkg::uop_t exp_uop;
        logic              exp_stall;
begin
        count       = int'(hdr[59:52]);
        hold_en     = hdr[34];
        flush_en    = hdr[35];
        errs_before = errors;
        i_instruction = hdr[31:0];
        i_valid     = 1'b1;
        i_irq       = hdr[32];
        i_fiq       = hdr[33];
        for (int i = 0; i < count; i++)
        begin
                exp_uop   = uop_seq_pkg::uop_t'(stim_mem[first + i][34:0]);
                exp_stall = stim_mem[first + i][36];
                // Masked after the first micro-op.
                first_irq = (i == 0) ? hdr[32] : 1'b0;
                first_fiq = (i == 0) ? hdr[33] : 1'b0;
                holds = hold_en ? int'($urandom % 3) : 0;
                i_hold = 1'b1;
                for (int h = 0; h < holds; h++)
                        sample_step(exp_uop, exp_stall, first_irq, first_fiq);
                i_hold = 1'b0;
                sample_step(exp_uop, exp_stall, first_irq, first_fiq);
        end
        // Abort mid-sequence, the next record must pass through.
        if (flush_en)
        begin
                i_flush = 1'b1;
                @(posedge i_clk);
                #1;
                i_flush = 1'b0;
        end
        tests++;
        $display("test %0d instr %h: %s", tests, hdr[31:0],
                 (errors == errs_before) ? "ok" : "mismatch");
end
endtask

////////////////////////////////////////////////////////////
// Main sequence.
////////////////////////////////////////////////////////////

initial
begin
        int          ptr;
        int unsigned total;

        i_reset       = 1'b1;
        i_flush       = 1'b0;
        i_hold        = 1'b0;
        i_valid       = 1'b0;
        i_irq         = 1'b0;
        i_fiq         = 1'b0;
        i_instruction = '0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        limit_cycles  = 0;
        void'($urandom(32'h2064));

        $readmemh("testbench/uop_stimulus.txt", stim_mem);

        // Sum the micro-ops for the watchdog.
        total = 0;
        ptr   = 0;
        while (stim_mem[ptr][59:52] != 8'd0)
        begin
                total = total + 32'(stim_mem[ptr][59:52]);
                ptr   = ptr + 1 + int'(stim_mem[ptr][59:52]);
        end
        limit_cycles = total * 4 + 64;

        repeat (2) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // Idle after reset with nothing valid.
        @(negedge i_clk);
        check_bit("o_stall", o_stall, 1'b0);
        check_bit("o_uop_valid", o_uop_valid, 1'b0);
        @(posedge i_clk);
        #1;

        ptr = 0;
        while (stim_mem[ptr][59:52] != 8'd0)
        begin
                run_record(stim_mem[ptr], ptr + 1);
                ptr = ptr + 1 + int'(stim_mem[ptr][59:52]);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
                $display("Testbench passed");
        else
                $display("Testbench failed");
        $finish;
end

// Watchdog sized from the stimulus.
initial
begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge i_clk);
        $display("Timeout: the micro-op sequences did not finish in time");
        $display("Testbench failed");
        $finish;
end

endmodule

`default_nettype wire

// ==== testbench/uop_sequencer_sva.sv ====
// Concurrent assertions for the micro-op sequencer.
// Reset state, interrupt masking, stall and hold.

`timescale 1ns/1ps
`default_nettype none

module uop_sequencer_sva
(
        input logic                    i_clk,
        input logic                    i_reset,
        input logic                    i_flush,
        input logic                    i_hold,
        input logic                    i_irq,
        input logic                    i_fiq,
        input logic                    o_stall,
        input logic                    o_irq,
        input logic                    o_fiq,
        input uop_seq_pkg::seq_state_t i_state
);

// Reset leaves the sequencer idle.
assert property (@(posedge i_clk) i_reset |=> i_state == uop_seq_pkg::IDLE)
        else $error("state not IDLE after reset");

// Interrupts only ride on the first micro-op.
// A SWAP shows SWAP_LOAD on its first micro-op, still from IDLE.
assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_state inside {uop_seq_pkg::IDLE, uop_seq_pkg::SWAP_LOAD})
        |-> !o_irq && !o_fiq)
        else $error("interrupt not masked inside a sequence");

assert property (@(posedge i_clk) disable iff (i_reset)
        i_state inside {uop_seq_pkg::IDLE, uop_seq_pkg::SWAP_LOAD}
        |-> o_irq == i_irq && o_fiq == i_fiq)
        else $error("interrupt not passed on the first micro-op");

// SWAP steps before the last stall, the closing steps do not.
assert property (@(posedge i_clk) disable iff (i_reset)
        i_state inside {uop_seq_pkg::SWAP_LOAD, uop_seq_pkg::SWAP_STORE,
                        uop_seq_pkg::SWAP_MOVE} |-> o_stall)
        else $error("stall low inside SWAP");

assert property (@(posedge i_clk) disable iff (i_reset)
        i_state inside {uop_seq_pkg::WRITE_PC, uop_seq_pkg::SWAP_FLUSH} |-> !o_stall)
        else $error("stall high on the last micro-op");

// Hold freezes the state.
assert property (@(posedge i_clk) disable iff (i_reset)
        i_hold && !i_flush |=> i_state == $past(i_state))
        else $error("state moved under hold");

endmodule

bind uop_sequencer uop_sequencer_sva uop_sequencer_sva_i
(
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_hold  (i_hold),
        .i_irq   (i_irq),
        .i_fiq   (i_fiq),
        .o_stall (o_stall),
        .o_irq   (o_irq),
        .o_fiq   (o_fiq),
        .i_state (state)
);

`default_nettype wire

// ==== design/uop_sequencer.sv ====
// Decode-stage micro-op sequencer, top level.
// Connects the state machine, register-list tracker
// and micro-op encoder.

`timescale 1ns/1ps
`default_nettype none

module uop_sequencer
(
        input  logic                i_clk,
        input  logic                i_reset,
        input  logic                i_flush,
        input  logic                i_hold,
        input  logic                i_valid,
        input  logic                i_irq,
        input  logic                i_fiq,
        input  uop_seq_pkg::instr_t i_instruction,
        output uop_seq_pkg::uop_t   o_uop,
        output logic                o_uop_valid,
        output logic                o_stall,
        output logic                o_irq,
        output logic                o_fiq
);

uop_seq_pkg::seq_state_t state;
logic                    load_list;
logic                    step;
logic                    list_empty;
uop_seq_pkg::reg_idx_t   next_reg;
uop_seq_pkg::offset_t    xfer_size;

// Sequencing control.
uop_seq_fsm uop_seq_fsm_i
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_flush        (i_flush),
        .i_hold         (i_hold),
        .i_valid        (i_valid),
        .i_irq          (i_irq),
        .i_fiq          (i_fiq),
        .i_list_empty   (list_empty),
        .i_instruction  (i_instruction),
        .o_state        (state),
        .o_load_list    (load_list),
        .o_step         (step),
        .o_stall        (o_stall),
        .o_uop_valid    (o_uop_valid),
        .o_irq          (o_irq),
        .o_fiq          (o_fiq)
);

// Register list of the held LDM/STM.
reglist_tracker reglist_tracker_i
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_flush        (i_flush),
        .i_load_list    (load_list),
        .i_step         (step),
        .i_list         (i_instruction[15:0]),
        .o_next_reg     (next_reg),
        .o_list_empty   (list_empty),
        .o_xfer_size    (xfer_size)
);

// Micro-op word.
uop_encoder uop_encoder_i
(
        .i_state        (state),
        .i_instruction  (i_instruction),
        .i_next_reg     (next_reg),
        .i_list_empty   (list_empty),
        .i_xfer_size    (xfer_size),
        .o_uop          (o_uop)
);

endmodule

`default_nettype wire

// ==== design/uop_encoder.sv ====
// Micro-op encoder of the sequencer.
// Forms the base backup, single transfers, base restore,
// PC write and SWAP steps from state and instruction.

`timescale 1ns/1ps
`default_nettype none

module uop_encoder
(
        input  uop_seq_pkg::seq_state_t i_state,
        input  uop_seq_pkg::instr_t     i_instruction,
        input  uop_seq_pkg::reg_idx_t   i_next_reg,
        input  logic                    i_list_empty,
        input  uop_seq_pkg::offset_t    i_xfer_size,
        output uop_seq_pkg::uop_t       o_uop
);

always_comb
begin
        logic [3:0] cond;
        logic       pre;
        logic       up;
        logic       byte_b;
        logic       wb;
        logic       load;
        logic       s_bit;
        logic [3:0] base;
        logic       pre_eff;

        // Instruction fields.
        cond   = i_instruction[31:28];
        pre    = i_instruction[24];
        up     = i_instruction[23];
        byte_b = i_instruction[22];
        wb     = i_instruction[21];
        s_bit  = i_instruction[22];
        load   = i_instruction[20];
        base   = i_instruction[19:16];

        // DA becomes IB and DB becomes IA off the lowered base.
        pre_eff = pre ^ ~up;

        // Pass-through by default.
        o_uop = {3'b000, i_instruction};

        case (i_state)
        uop_seq_pkg::IDLE:
        begin
                if (i_instruction[27:25] == 3'b100)
                begin
                        if (up)
                                // MOV DUMMY0, base.
                                o_uop = {3'b000, cond, 2'b00, 1'b0, uop_seq_pkg::OP_MOV,
                                         1'b0, 4'd0, 4'd0, 8'd0, base};
                        else
                                // SUB DUMMY0, base, #size.
                                o_uop = {3'b000, cond, 2'b00, 1'b1, uop_seq_pkg::OP_SUB,
                                         1'b0, base, 4'd0, i_xfer_size};
                        {o_uop[33], o_uop[15:12]} = uop_seq_pkg::DUMMY0;
                end
        end

        uop_seq_pkg::MEMOP:
        begin
                if (!i_list_empty)
                begin
                        // LDR/STR next, [DUMMY0], #4 word, increment.
                        // Pre-indexed forms write back DUMMY0 explicitly.
                        o_uop = {3'b000, cond, 2'b01, 1'b0, pre_eff, 1'b1, 1'b0,
                                 pre_eff, load, 4'd0, i_next_reg,
                                 uop_seq_pkg::WORD_BYTES};
                        {o_uop[32], o_uop[19:16]} = uop_seq_pkg::DUMMY0;

                        // PC is loaded aside and written last.
                        if (load && (i_next_reg == uop_seq_pkg::REG_PC))
                                {o_uop[33], o_uop[15:12]} = uop_seq_pkg::DUMMY1;
                end
                else if (wb && up)
                begin
                        // MOV base, DUMMY0. DUMMY0 ends at the new base.
                        o_uop = {3'b000, cond, 2'b00, 1'b0, uop_seq_pkg::OP_MOV,
                                 1'b0, 4'd0, base, 8'd0, 4'd0};
                        {o_uop[34], o_uop[3:0]} = uop_seq_pkg::DUMMY0;
                end
                else if (wb)
                begin
                        // SUB base, base, #size.
                        o_uop = {3'b000, cond, 2'b00, 1'b1, uop_seq_pkg::OP_SUB,
                                 1'b0, base, base, i_xfer_size};
                end
                else
                begin
                        // No writeback, empty slot.
                        o_uop = '0;
                end
        end

        uop_seq_pkg::WRITE_PC:
        begin
                // MOV(S) PC, DUMMY1.
                o_uop = {3'b000, cond, 2'b00, 1'b0, uop_seq_pkg::OP_MOV,
                         s_bit, 4'd0, uop_seq_pkg::REG_PC, 8'd0, 4'd0};
                {o_uop[34], o_uop[3:0]} = uop_seq_pkg::DUMMY1;
        end

        uop_seq_pkg::SWAP_LOAD:
        begin
                // LDR(B) DUMMY0, [Rn].
                // Reading into a dummy register changes no visible state.
                o_uop = {3'b000, uop_seq_pkg::COND_AL, 2'b01, 1'b0, 1'b1, 1'b1,
                         byte_b, 1'b0, 1'b1, base, 4'd0, 12'd0};
                {o_uop[33], o_uop[15:12]} = uop_seq_pkg::DUMMY0;
        end

        uop_seq_pkg::SWAP_STORE,
        uop_seq_pkg::SWAP_FLUSH:
        begin
                // STR(B) Rm, [Rn]. Issued twice to drain the write buffer.
                o_uop = {3'b000, cond, 2'b01, 1'b0, 1'b1, 1'b1, byte_b, 1'b0,
                         1'b0, base, i_instruction[3:0], 12'd0};
        end

        uop_seq_pkg::SWAP_MOVE:
        begin
                // MOV Rd, DUMMY0.
                o_uop = {3'b000, cond, 2'b00, 1'b0, uop_seq_pkg::OP_MOV, 1'b0,
                         4'd0, i_instruction[15:12], 8'd0, 4'd0};
                {o_uop[34], o_uop[3:0]} = uop_seq_pkg::DUMMY0;
        end

        default:
        begin
                o_uop = {3'b000, i_instruction};
        end
        endcase
end

endmodule

`default_nettype wire

// ==== design/reglist_tracker.sv ====
// Register-list tracker for LDM/STM sequencing.
// Holds the remaining list, picks the lowest register
// and sizes the whole transfer.

`timescale 1ns/1ps
`default_nettype none

module reglist_tracker
(
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_flush,
        input  logic                  i_load_list,
        input  logic                  i_step,
        input  uop_seq_pkg::reglist_t i_list,
        output uop_seq_pkg::reg_idx_t o_next_reg,
        output logic                  o_list_empty,
        output uop_seq_pkg::offset_t  o_xfer_size
);

// Registers still to transfer.
uop_seq_pkg::reglist_t list_ff;

// Up to 16 ones.
logic [4:0] ones;

always_ff @(posedge i_clk)
begin
        if (i_reset || i_flush)
                list_ff <= '0;
        else if (i_load_list)
                list_ff <= i_list;
        else if (i_step)
                // Drop the lowest set bit.
                list_ff <= list_ff & (list_ff - 16'd1);
end

assign o_list_empty = (list_ff == '0);

// Priority encoder, lowest register first.
always_comb
begin
        o_next_reg = '0;
        for (int i = 15; i >= 0; i--)
        begin
                if (list_ff[i])
                        o_next_reg = uop_seq_pkg::reg_idx_t'(i);
        end
end

// Size comes from the instruction's full list, not the remainder.
always_comb
begin
        ones = '0;
        for (int i = 0; i < 16; i++)
                ones = ones + 5'(i_list[i]);
        o_xfer_size = uop_seq_pkg::offset_t'(ones) * uop_seq_pkg::WORD_BYTES;
end

endmodule

`default_nettype wire

// ==== design/uop_seq_fsm.sv ====
// Sequencing state machine of the micro-op sequencer.
// Classifies the instruction, walks the sequence states,
// drives stall and valid, and masks interrupts mid-sequence.

`timescale 1ns/1ps
`default_nettype none

module uop_seq_fsm
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic                    i_flush,
        input  logic                    i_hold,
        input  logic                    i_valid,
        input  logic                    i_irq,
        input  logic                    i_fiq,
        input  logic                    i_list_empty,
        input  uop_seq_pkg::instr_t     i_instruction,
        output uop_seq_pkg::seq_state_t o_state,
        output logic                    o_load_list,
        output logic                    o_step,
        output logic                    o_stall,
        output logic                    o_uop_valid,
        output logic                    o_irq,
        output logic                    o_fiq
);

uop_seq_pkg::seq_state_t state_ff;
uop_seq_pkg::seq_state_t state_nxt;

logic is_block;
logic is_swap;
logic is_load_pc;
logic start_block;

////////////////////////////////////////////////////////////
// Classification.
////////////////////////////////////////////////////////////

// LDM/STM space.
assign is_block = i_valid && (i_instruction[27:25] == 3'b100);

assign is_swap = i_valid &&
        ((i_instruction & uop_seq_pkg::SWAP_MASK) == uop_seq_pkg::SWAP_PATTERN);

// A load with PC in the list needs the final PC write.
assign is_load_pc = i_instruction[20] && i_instruction[uop_seq_pkg::REG_PC];

////////////////////////////////////////////////////////////
// Next state and stall.
////////////////////////////////////////////////////////////

always_comb
begin
        state_nxt   = state_ff;
        o_state     = state_ff;
        o_stall     = 1'b0;
        start_block = 1'b0;

        case (state_ff)
        uop_seq_pkg::IDLE:
        begin
                if (is_block)
                begin
                        // Base backup goes out now, list is captured.
                        start_block = 1'b1;
                        o_stall     = 1'b1;
                        state_nxt   = uop_seq_pkg::MEMOP;
                end
                else if (is_swap)
                begin
                        // The load of a SWAP issues straight from IDLE.
                        o_state   = uop_seq_pkg::SWAP_LOAD;
                        o_stall   = 1'b1;
                        state_nxt = uop_seq_pkg::SWAP_STORE;
                end
        end

        uop_seq_pkg::MEMOP:
        begin
                if (!i_list_empty)
                begin
                        o_stall = 1'b1;
                end
                else if (is_load_pc)
                begin
                        o_stall   = 1'b1;
                        state_nxt = uop_seq_pkg::WRITE_PC;
                end
                else
                begin
                        // Base restore is the last micro-op.
                        state_nxt = uop_seq_pkg::IDLE;
                end
        end

        uop_seq_pkg::SWAP_LOAD,
        uop_seq_pkg::SWAP_STORE:
        begin
                o_stall   = 1'b1;
                state_nxt = uop_seq_pkg::SWAP_MOVE;
        end

        uop_seq_pkg::SWAP_MOVE:
        begin
                o_stall   = 1'b1;
                state_nxt = uop_seq_pkg::SWAP_FLUSH;
        end

        // WRITE_PC and SWAP_FLUSH end a sequence.
        default:
        begin
                state_nxt = uop_seq_pkg::IDLE;
        end
        endcase
end

// Flush wins over hold.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_flush)
                state_ff <= uop_seq_pkg::IDLE;
        else if (!i_hold)
                state_ff <= state_nxt;
end

////////////////////////////////////////////////////////////
// Tracker control and outputs.
////////////////////////////////////////////////////////////

// Nothing advances while held.
assign o_load_list = start_block && !i_hold;
assign o_step      = (state_ff == uop_seq_pkg::MEMOP) && !i_hold;

// Every micro-op inside a sequence is valid.
assign o_uop_valid = (state_ff == uop_seq_pkg::IDLE) ? i_valid : 1'b1;

// Interrupts ride only on the first micro-op.
assign o_irq = (state_ff == uop_seq_pkg::IDLE) && i_irq;
assign o_fiq = (state_ff == uop_seq_pkg::IDLE) && i_fiq;

endmodule

`default_nettype wire

// ==== design/uop_seq_pkg.sv ====
// Shared definitions of the micro-op sequencer.
// Word types, sequencer states, ARM opcodes and
// the internal dummy register numbers.

`default_nettype none

package uop_seq_pkg;

        ////////////////////////////////////////////////////////////
        // Word types.
        ////////////////////////////////////////////////////////////

        // Architectural instruction from fetch.
        typedef logic [31:0] instr_t;

        // ARM word in 31..0, Rn/Rd/Rm extension bits in 32/33/34.
        typedef logic [34:0] uop_t;

        // Architectural register number.
        typedef logic [3:0] reg_idx_t;

        // LDM/STM register list.
        typedef logic [15:0] reglist_t;

        // Immediate offset, four bytes per listed register.
        typedef logic [11:0] offset_t;

        // Sequencer states.
        typedef enum logic [2:0] {
                IDLE,
                MEMOP,
                WRITE_PC,
                SWAP_LOAD,
                SWAP_STORE,
                SWAP_MOVE,
                SWAP_FLUSH
        } seq_state_t;

        ////////////////////////////////////////////////////////////
        // Encodings.
        ////////////////////////////////////////////////////////////

        // Condition "always".
        localparam logic [3:0] COND_AL = 4'b1110;

        // Data-processing opcodes.
        localparam logic [3:0] OP_MOV = 4'b1101;
        localparam logic [3:0] OP_SUB = 4'b0010;

        localparam reg_idx_t REG_PC = 4'd15;

        // Dummy registers as {extension, field}.
        // DUMMY0 backs up the base, DUMMY1 catches a loaded PC.
        localparam logic [4:0] DUMMY0 = 5'b1_0000;
        localparam logic [4:0] DUMMY1 = 5'b1_0001;

        // One word per transferred register.
        localparam offset_t WORD_BYTES = 12'd4;

        // SWP/SWPB: cond 0001 0B00 Rn Rd 0000 1001 Rm.
        localparam instr_t SWAP_PATTERN = 32'h0100_0090;
        localparam instr_t SWAP_MASK    = 32'h0FB0_0FF0;

endpackage

`default_nettype wire
